//--- src/lm80c_defs.svh
// bus widths, I/O port pages, LED port, RAM window and erase fill; include in any RTL file that needs them
`ifndef LM80C_DEFS_SVH
`define LM80C_DEFS_SVH

// z80 address and data bus widths
`define LM80C_ADDR_W 16
`define LM80C_DATA_W 8

// device pages
// compared against I/O address bits 7..4
`define LM80C_PAGE_PIO 4'h0
`define LM80C_PAGE_CTC 4'h1
`define LM80C_PAGE_SIO 4'h2
`define LM80C_PAGE_VDP 4'h3
`define LM80C_PAGE_PSG 4'h4

// debug LED latch port
// full 8 bit match, overrides the page decode
`define LM80C_LED_PORT 8'hFF

// writable RAM window for the CPU
// base is inclusive, end is exclusive
`define LM80C_RAM_BASE 16'h8000
`define LM80C_RAM_END 16'hC000

// byte written by the eraser sweep
`define LM80C_ERASE_FILL 8'h00

`endif

//--- src/lm80c_pkg.sv
// shared bus types and enums for the LM80C front end; import with a wildcard in each module header
`default_nettype none

`include "lm80c_defs.svh"

package lm80c_pkg;

	// cpu and ram address
	typedef logic [`LM80C_ADDR_W-1:0] addr_t;

	// data byte on every bus
	typedef logic [`LM80C_DATA_W-1:0] byte_t;

	// registered I/O source selected by the decoder
	// none means a memory cycle, read data comes from RAM
	typedef enum logic [2:0] {
		IO_NONE = 3'd0,
		IO_PIO  = 3'd1,
		IO_CTC  = 3'd2,
		IO_SIO  = 3'd3,
		IO_VDP  = 3'd4,
		IO_PSG  = 3'd5,
		IO_LED  = 3'd6
	} io_dev_e;

	// current owner of the RAM port
	// download beats eraser beats cpu
	typedef enum logic [1:0] {
		SRC_CPU      = 2'd0,
		SRC_DOWNLOAD = 2'd1,
		SRC_ERASER   = 2'd2
	} ram_src_e;

endpackage

`default_nettype wire

//--- src/sysram.sv
// 64 KiB single port byte RAM with registered read, instantiated by the RAM arbiter
`default_nettype none

module sysram
	import lm80c_pkg::*;
(
	input  logic  ram_clock,
	input  addr_t addr_i,
	input  byte_t data_i,
	input  logic  wr_i,
	output byte_t q_o
);

	// one byte per cpu address
	localparam int DEPTH = 2 ** $bits(addr_t);

	byte_t mem [DEPTH];

	// registered read sees the old contents on a write cycle
	always_ff @(posedge ram_clock) begin
		if (wr_i) begin
			mem[addr_i] <= data_i;
		end
		q_o <= mem[addr_i];
	end

endmodule

`default_nettype wire

//--- src/io_decoder.sv
// registered Z80 I/O decode with device selects, VDP/PSG/CTC strobes and the debug LED latch
`default_nettype none

`include "lm80c_defs.svh"

module io_decoder
	import lm80c_pkg::*;
(
	input  logic    ram_clock,
	input  logic    RESET,
	input  addr_t   addr_i,
	input  logic    rd_i,
	input  logic    wr_i,
	input  logic    iorq_i,
	input  logic    mreq_i,
	input  byte_t   dout_i,
	output io_dev_e io_dev_o,
	output byte_t   led_data_o,
	output logic    led_o,
	output logic    vdp_csr_n_o,
	output logic    vdp_csw_n_o,
	output logic    psg_bdir_o,
	output logic    psg_bc_o,
	output logic    ctc_ce_n_o
);

	logic       io_cyc;
	logic [3:0] page;
	io_dev_e    dev_nxt;
	logic       vdp_hit;
	logic       psg_hit;
	logic       ctc_hit;

	// only a true I/O cycle decodes, never a memory cycle
	assign io_cyc = iorq_i & ~mreq_i;
	// z80 I/O ports live in the low byte
	assign page = addr_i[7:4];

	always_comb begin
		dev_nxt = IO_NONE;
		if (io_cyc) begin
			// port 0xFF wins over its page
			if (addr_i[7:0] == `LM80C_LED_PORT) begin
				dev_nxt = IO_LED;
			end else begin
				case (page)
					`LM80C_PAGE_PIO: dev_nxt = IO_PIO;
					`LM80C_PAGE_CTC: dev_nxt = IO_CTC;
					`LM80C_PAGE_SIO: dev_nxt = IO_SIO;
					`LM80C_PAGE_VDP: dev_nxt = IO_VDP;
					`LM80C_PAGE_PSG: dev_nxt = IO_PSG;
					default:         dev_nxt = IO_NONE;
				endcase
			end
		end
	end

	assign vdp_hit = (dev_nxt == IO_VDP);
	assign psg_hit = (dev_nxt == IO_PSG);
	assign ctc_hit = (dev_nxt == IO_CTC);

	// selects and strobes, one edge behind the bus
	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			io_dev_o    <= IO_NONE;
			vdp_csr_n_o <= 1'b1;
			vdp_csw_n_o <= 1'b1;
			psg_bdir_o  <= 1'b0;
			psg_bc_o    <= 1'b0;
			ctc_ce_n_o  <= 1'b1;
		end else begin
			io_dev_o    <= dev_nxt;
			// vdp read and write strobes, active low
			vdp_csr_n_o <= ~(vdp_hit & rd_i);
			vdp_csw_n_o <= ~(vdp_hit & wr_i);
			// psg bus control, bc follows address bit 0 inverted
			psg_bdir_o  <= psg_hit & wr_i;
			psg_bc_o    <= psg_hit & ~addr_i[0];
			ctc_ce_n_o  <= ~ctc_hit;
		end
	end

	// LED latch loads once the registered select meets a write
	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			led_data_o <= '0;
		end else if ((io_dev_o == IO_LED) && wr_i && iorq_i) begin
			led_data_o <= dout_i;
		end
	end

	// lit for any nonzero latch value
	assign led_o = |led_data_o;

endmodule

`default_nettype wire

//--- src/eraser.sv
// clears the RAM window one address per cycle after a trigger strobe, busy while sweeping
`default_nettype none

`include "lm80c_defs.svh"

module eraser
	import lm80c_pkg::*;
(
	input  logic  ram_clock,
	input  logic  RESET,
	input  logic  trigger_i,
	output logic  busy_o,
	output logic  wr_o,
	output addr_t addr_o
);

	// last address inside the window
	localparam addr_t LAST_ADDR = addr_t'(`LM80C_RAM_END - 16'd1);

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			busy_o <= 1'b0;
			addr_o <= `LM80C_RAM_BASE;
		end else if (!busy_o) begin
			// start of sweep
			if (trigger_i) begin
				busy_o <= 1'b1;
				addr_o <= `LM80C_RAM_BASE;
			end
		end else begin
			// retrigger while busy has no effect
			if (addr_o == LAST_ADDR) begin
				busy_o <= 1'b0;
			end else begin
				addr_o <= addr_o + addr_t'(1);
			end
		end
	end

	// one write per busy cycle, 16384 in total
	assign wr_o = busy_o;

endmodule

`default_nettype wire

//--- src/ram_arbiter.sv
// picks the RAM owner (download, eraser, cpu), registers its request and drives the system RAM
`default_nettype none

`include "lm80c_defs.svh"

module ram_arbiter
	import lm80c_pkg::*;
(
	input  logic  ram_clock,
	input  logic  RESET,
	input  addr_t cpu_addr_i,
	input  byte_t cpu_dout_i,
	input  logic  cpu_wr_i,
	input  logic  cpu_mreq_i,
	input  logic  dl_active_i,
	input  logic  dl_wr_i,
	input  addr_t dl_addr_i,
	input  byte_t dl_data_i,
	input  logic  erase_busy_i,
	input  logic  erase_wr_i,
	input  addr_t erase_addr_i,
	output byte_t ram_q_o,
	output logic  wait_o
);

	ram_src_e src;
	logic     cpu_win;
	addr_t    ram_addr;
	byte_t    ram_data;
	logic     ram_wr;

	// cpu may only write between base and end
	assign cpu_win = (cpu_addr_i >= `LM80C_RAM_BASE) && (cpu_addr_i < `LM80C_RAM_END);

	// fixed priority
	always_comb begin
		if (dl_active_i) begin
			src = SRC_DOWNLOAD;
		end else if (erase_busy_i) begin
			src = SRC_ERASER;
		end else begin
			src = SRC_CPU;
		end
	end

	// address and data of the winner
	always_ff @(posedge ram_clock) begin
		case (src)
			SRC_DOWNLOAD: begin
				ram_addr <= dl_addr_i;
				ram_data <= dl_data_i;
			end
			SRC_ERASER: begin
				ram_addr <= erase_addr_i;
				ram_data <= `LM80C_ERASE_FILL;
			end
			default: begin
				ram_addr <= cpu_addr_i;
				ram_data <= cpu_dout_i;
			end
		endcase
	end

	// write enable and cpu wait
	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			ram_wr <= 1'b0;
			wait_o <= 1'b0;
		end else begin
			// cpu held off while RAM belongs to someone else
			wait_o <= dl_active_i | erase_busy_i;
			case (src)
				SRC_DOWNLOAD: ram_wr <= dl_wr_i;
				SRC_ERASER:   ram_wr <= erase_wr_i;
				default:      ram_wr <= cpu_wr_i & cpu_mreq_i & cpu_win;
			endcase
		end
	end

	// read data lands one edge after the registered address
	sysram u_sysram (
		.ram_clock (ram_clock),
		.addr_i    (ram_addr),
		.data_i    (ram_data),
		.wr_i      (ram_wr),
		.q_o       (ram_q_o)
	);

endmodule

`default_nettype wire

//--- src/cpu_read_mux.sv
// registered CPU read data from the selected I/O device, LED latch or RAM, also used for int ack
`default_nettype none

`include "lm80c_defs.svh"

module cpu_read_mux
	import lm80c_pkg::*;
(
	input  logic    ram_clock,
	input  logic    RESET,
	input  logic    rd_i,
	input  logic    iorq_i,
	input  logic    m1_i,
	input  io_dev_e io_dev_i,
	input  byte_t   led_data_i,
	input  byte_t   ctc_data_i,
	input  byte_t   vdp_data_i,
	input  byte_t   psg_data_i,
	input  byte_t   ram_q_i,
	output byte_t   cpu_din_o
);

	byte_t rd_sel;

	// source by registered device select
	always_comb begin
		case (io_dev_i)
			// no read data modelled for pio and sio
			IO_PIO:  rd_sel = {`LM80C_DATA_W{1'b0}};
			IO_CTC:  rd_sel = ctc_data_i;
			IO_SIO:  rd_sel = {`LM80C_DATA_W{1'b0}};
			IO_VDP:  rd_sel = vdp_data_i;
			IO_PSG:  rd_sel = psg_data_i;
			IO_LED:  rd_sel = led_data_i;
			default: rd_sel = ram_q_i;
		endcase
	end

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			cpu_din_o <= '0;
		end else if (rd_i) begin
			cpu_din_o <= rd_sel;
		end else if (iorq_i && m1_i) begin
			// interrupt acknowledge, ctc supplies the vector
			cpu_din_o <= ctc_data_i;
		end
	end

endmodule

`default_nettype wire

//--- src/lm80c_bus.sv
// LM80C Z80 bus front end top level; connects I/O decoder, eraser, RAM arbiter and read mux
`default_nettype none

`include "lm80c_defs.svh"

module lm80c_bus
	import lm80c_pkg::*;
(
	input  logic  ram_clock,
	input  logic  RESET,
	input  addr_t cpu_addr_i,
	input  byte_t cpu_dout_i,
	input  logic  cpu_rd_i,
	input  logic  cpu_wr_i,
	input  logic  cpu_iorq_i,
	input  logic  cpu_mreq_i,
	input  logic  cpu_m1_i,
	input  byte_t ctc_data_i,
	input  byte_t vdp_data_i,
	input  byte_t psg_data_i,
	input  logic  dl_active_i,
	input  logic  dl_wr_i,
	input  addr_t dl_addr_i,
	input  byte_t dl_data_i,
	input  logic  erase_i,
	output byte_t cpu_din_o,
	output logic  wait_o,
	output logic  vdp_csr_n_o,
	output logic  vdp_csw_n_o,
	output logic  psg_bdir_o,
	output logic  psg_bc_o,
	output logic  ctc_ce_n_o,
	output logic  led_o
);

	io_dev_e io_dev;
	byte_t   led_data;
	logic    erase_busy;
	logic    erase_wr;
	addr_t   erase_addr;
	byte_t   ram_q;

	// I/O decode and LED latch
	io_decoder u_io_decoder (
		.ram_clock   (ram_clock),
		.RESET       (RESET),
		.addr_i      (cpu_addr_i),
		.rd_i        (cpu_rd_i),
		.wr_i        (cpu_wr_i),
		.iorq_i      (cpu_iorq_i),
		.mreq_i      (cpu_mreq_i),
		.dout_i      (cpu_dout_i),
		.io_dev_o    (io_dev),
		.led_data_o  (led_data),
		.led_o       (led_o),
		.vdp_csr_n_o (vdp_csr_n_o),
		.vdp_csw_n_o (vdp_csw_n_o),
		.psg_bdir_o  (psg_bdir_o),
		.psg_bc_o    (psg_bc_o),
		.ctc_ce_n_o  (ctc_ce_n_o)
	);

	// window sweep
	eraser u_eraser (
		.ram_clock (ram_clock),
		.RESET     (RESET),
		.trigger_i (erase_i),
		.busy_o    (erase_busy),
		.wr_o      (erase_wr),
		.addr_o    (erase_addr)
	);

	// shared RAM port
	ram_arbiter u_ram_arbiter (
		.ram_clock    (ram_clock),
		.RESET        (RESET),
		.cpu_addr_i   (cpu_addr_i),
		.cpu_dout_i   (cpu_dout_i),
		.cpu_wr_i     (cpu_wr_i),
		.cpu_mreq_i   (cpu_mreq_i),
		.dl_active_i  (dl_active_i),
		.dl_wr_i      (dl_wr_i),
		.dl_addr_i    (dl_addr_i),
		.dl_data_i    (dl_data_i),
		.erase_busy_i (erase_busy),
		.erase_wr_i   (erase_wr),
		.erase_addr_i (erase_addr),
		.ram_q_o      (ram_q),
		.wait_o       (wait_o)
	);

	// cpu data in
	cpu_read_mux u_cpu_read_mux (
		.ram_clock  (ram_clock),
		.RESET      (RESET),
		.rd_i       (cpu_rd_i),
		.iorq_i     (cpu_iorq_i),
		.m1_i       (cpu_m1_i),
		.io_dev_i   (io_dev),
		.led_data_i (led_data),
		.ctc_data_i (ctc_data_i),
		.vdp_data_i (vdp_data_i),
		.psg_data_i (psg_data_i),
		.ram_q_i    (ram_q),
		.cpu_din_o  (cpu_din_o)
	);

endmodule

`default_nettype wire

//--- tests/tb_lm80c_bus.sv
// testbench for the LM80C bus front end, replays tests/bus_tests.txt; run from the project root
`default_nettype none

`include "lm80c_defs.svh"

module tb_lm80c_bus
	import lm80c_pkg::*;
();

	localparam int RESET_CYCLES = 8;
	// eraser sweep is 16384 cycles plus pipeline slack
	localparam int ERASE_BOUND = 16400;

	logic  ram_clock;
	logic  RESET;
	// cpu bus
	addr_t cpu_addr_i;
	byte_t cpu_dout_i;
	logic  cpu_rd_i, cpu_wr_i, cpu_iorq_i, cpu_mreq_i, cpu_m1_i;
	// peripheral read data
	byte_t ctc_data_i, vdp_data_i, psg_data_i;
	// rom download and erase strobe
	logic  dl_active_i, dl_wr_i, erase_i;
	addr_t dl_addr_i;
	byte_t dl_data_i;
	// dut outputs
	byte_t cpu_din_o;
	logic  wait_o, vdp_csr_n_o, vdp_csw_n_o, psg_bdir_o, psg_bc_o, ctc_ce_n_o, led_o;

	// transactions read from the data file
	byte_t op_q[$];
	addr_t addr_q[$];
	byte_t data_q[$];
	byte_t exp_q[$];

	logic [31:0] lfsr;
	int          cycles;
	int          limit;

	lm80c_bus u_dut (.*);

	initial begin
		ram_clock = 1'b0;
		forever #4 ram_clock = ~ram_clock;
	end

	// run limit, armed once the file is read
	always @(posedge ram_clock) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("simulation timed out after %0d cycles", cycles);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit taken
	task automatic draw_byte(output byte_t b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic refresh_peripherals();
		draw_byte(ctc_data_i);
		draw_byte(vdp_data_i);
		draw_byte(psg_data_i);
	endtask

	task automatic report_failure();
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic expect_byte(input string what, input byte_t got, input byte_t exp);
		assert (got === exp) else begin
			$display("[FAIL] %0t: %s read %02h, expected %02h", $time, what, got, exp);
			report_failure();
		end
	endtask

	task automatic expect_bit(input string what, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
			report_failure();
		end
	endtask

	// every bus and download input inactive
	task automatic idle_bus();
		cpu_addr_i = '0;
		cpu_dout_i = '0;
		cpu_rd_i = 1'b0;
		cpu_wr_i = 1'b0;
		cpu_iorq_i = 1'b0;
		cpu_mreq_i = 1'b0;
		cpu_m1_i = 1'b0;
		dl_active_i = 1'b0;
		dl_wr_i = 1'b0;
		dl_addr_i = '0;
		dl_data_i = '0;
		erase_i = 1'b0;
	endtask

	// four rising edges, then sample on the falling one
	task automatic hold_bus();
		repeat (4) @(posedge ram_clock);
		@(negedge ram_clock);
	endtask

	// strobe, then wait_o must rise and later fall
	task automatic erase_window();
		int n;
		erase_i = 1'b1;
		@(negedge ram_clock);
		erase_i = 1'b0;
		n = 0;
		while (!wait_o && n < 16) begin
			@(negedge ram_clock);
			n++;
		end
		assert (wait_o) else begin
			$display("wait_o never rose after the erase strobe");
			report_failure();
		end
		n = 0;
		while (wait_o && n < ERASE_BOUND) begin
			@(negedge ram_clock);
			n++;
		end
		assert (!wait_o) else begin
			$display("wait_o still high %0d cycles into the erase", ERASE_BOUND);
			report_failure();
		end
	endtask

	// one file line, starting and ending on a falling edge
	task automatic run_one(input byte_t op, input addr_t a, input byte_t d, input byte_t e);
		byte_t exp;
		exp = e;
		cpu_addr_i = a;
		cpu_dout_i = d;
		case (op)
			"D": begin
				dl_active_i = 1'b1;
				dl_wr_i = 1'b1;
				dl_addr_i = a;
				dl_data_i = d;
				// single cycle byte strobe
				@(negedge ram_clock);
				dl_wr_i = 1'b0;
				repeat (3) @(posedge ram_clock);
				@(negedge ram_clock);
				expect_bit("wait_o during download", wait_o, 1'b1);
			end
			"W": begin
				cpu_mreq_i = 1'b1;
				cpu_wr_i = 1'b1;
				hold_bus();
			end
			"R": begin
				cpu_mreq_i = 1'b1;
				cpu_rd_i = 1'b1;
				hold_bus();
				expect_byte("memory read", cpu_din_o, exp);
			end
			"O": begin
				refresh_peripherals();
				cpu_iorq_i = 1'b1;
				cpu_wr_i = 1'b1;
				hold_bus();
				if (a[7:0] == `LM80C_LED_PORT) begin
					expect_bit("led_o", led_o, d != 8'h00);
				end else if (a[7:4] == `LM80C_PAGE_PSG && !a[0]) begin
					// psg address latch write
					expect_bit("psg_bdir_o", psg_bdir_o, 1'b1);
					expect_bit("psg_bc_o", psg_bc_o, 1'b1);
				end
			end
			"I": begin
				refresh_peripherals();
				cpu_iorq_i = 1'b1;
				cpu_rd_i = 1'b1;
				// live device pages return their input, others keep the file value
				if (a[7:0] != `LM80C_LED_PORT) begin
					case (a[7:4])
						`LM80C_PAGE_CTC: exp = ctc_data_i;
						`LM80C_PAGE_VDP: exp = vdp_data_i;
						`LM80C_PAGE_PSG: exp = psg_data_i;
						default: ;
					endcase
				end
				hold_bus();
				expect_byte("io read", cpu_din_o, exp);
				if (a[7:0] != `LM80C_LED_PORT) begin
					// chip enables follow the page of a read
					expect_bit("vdp_csr_n_o", vdp_csr_n_o, a[7:4] != `LM80C_PAGE_VDP);
					expect_bit("vdp_csw_n_o", vdp_csw_n_o, 1'b1);
					expect_bit("ctc_ce_n_o", ctc_ce_n_o, a[7:4] != `LM80C_PAGE_CTC);
				end
			end
			"A": begin
				refresh_peripherals();
				cpu_iorq_i = 1'b1;
				cpu_m1_i = 1'b1;
				exp = ctc_data_i;
				hold_bus();
				expect_byte("interrupt vector", cpu_din_o, exp);
			end
			"E": begin
				erase_window();
			end
			default: begin
				$display("unknown operation %c in the test file", op);
				report_failure();
			end
		endcase
		idle_bus();
		@(negedge ram_clock);
	endtask

	initial begin
		int    fd;
		string line;
		byte_t op;
		addr_t a;
		byte_t d;
		byte_t e;
		lfsr = 32'h5c4c_1ee7;
		RESET = 1'b1;
		ctc_data_i = '0;
		vdp_data_i = '0;
		psg_data_i = '0;
		idle_bus();
		fd = $fopen("tests/bus_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open tests/bus_tests.txt");
			report_failure();
		end
		// skip comments and blank lines
		while (!$feof(fd)) begin
			if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
				if ($sscanf(line, "%c %h %h %h", op, a, d, e) == 4) begin
					op_q.push_back(op);
					addr_q.push_back(a);
					data_q.push_back(d);
					exp_q.push_back(e);
				end
			end
		end
		$fclose(fd);
		limit = op_q.size() * 8 + ERASE_BOUND + RESET_CYCLES;
		repeat (RESET_CYCLES) @(posedge ram_clock);
		@(negedge ram_clock);
		RESET = 1'b0;
		// state straight out of reset
		expect_byte("cpu_din_o after reset", cpu_din_o, 8'h00);
		expect_bit("wait_o after reset", wait_o, 1'b0);
		expect_bit("led_o after reset", led_o, 1'b0);
		// strobes idle, active low selects high
		expect_bit("vdp_csr_n_o after reset", vdp_csr_n_o, 1'b1);
		expect_bit("vdp_csw_n_o after reset", vdp_csw_n_o, 1'b1);
		expect_bit("psg_bdir_o after reset", psg_bdir_o, 1'b0);
		expect_bit("psg_bc_o after reset", psg_bc_o, 1'b0);
		expect_bit("ctc_ce_n_o after reset", ctc_ce_n_o, 1'b1);
		foreach (op_q[i]) begin
			run_one(op_q[i], addr_q[i], data_q[i], exp_q[i]);
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+src
src/lm80c_pkg.sv
src/sysram.sv
src/io_decoder.sv
src/eraser.sv
src/ram_arbiter.sv
src/cpu_read_mux.sv
src/lm80c_bus.sv
tests/tb_lm80c_bus.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_lm80c_bus
FILELIST  = tb.f

.PHONY: sim clean

# build and run from the project root, pass only when the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

//--- tests/bus_tests.txt
# columns: op addr data expect, all hex
# op: D download, W mem write, R mem read, O io write, I io read, A int ack, E erase
D 0000 3E 00
D 0001 5A 00
D 0010 C3 00
D 7FFF A5 00
R 0000 00 3E
R 0001 00 5A
R 0010 00 C3
R 7FFF 00 A5
W 8000 11 00
W 9234 77 00
W BFFF EE 00
R 8000 00 11
R 9234 00 77
R BFFF 00 EE
W 0010 99 00
R 0010 00 C3
I 0010 00 00
I 0030 00 00
I 0041 00 00
I 0000 00 00
I 0020 00 00
O 0040 12 00
O 00FF 5C 00
I 00FF 00 5C
O 00FF 00 00
I 00FF 00 00
A 0000 00 00
E 0000 00 00
R 8000 00 00
R 9234 00 00
R BFFF 00 00
R 0000 00 3E
R 7FFF 00 A5
R 0010 00 C3
